//--- include/icache_consts.svh
// geometry of the instruction cache, 32-bit words on a 32-bit physical address
// the field widths are not derived, so keep them in step with line size and sets
// tag + index + word select + byte select must add up to the address width

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// word and address widths
`define ICACHE_XLEN 32
`define ICACHE_PLEN 32

// organisation
`define ICACHE_LINE_WORDS 4
`define ICACHE_WAYS 2
`define ICACHE_WAY_BITS 1
`define ICACHE_SETS 8

// address fields, low to high
`define ICACHE_BSEL_BITS 2
`define ICACHE_OFFS_BITS 4
`define ICACHE_WSEL_BITS (`ICACHE_OFFS_BITS - `ICACHE_BSEL_BITS)
`define ICACHE_IDX_BITS 3
`define ICACHE_TAG_BITS 25

`endif

//--- project.f
+incdir+include
source/icache_pkg.sv
source/icache_hit.sv
source/icache_mem.sv
source/icache_fill.sv
source/icache_top.sv
sim/icache_sva.sv
sim/icache_tb.sv

//--- sim/icache_sva.sv
// assertions on the instruction cache, bound into the top level
// recovery is seen as the fill write, the end of an invalidate or a fill error

`timescale 1ns/1ns

module icache_sva
(
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 stall_i,
  input logic                 valid_i,
  input logic                 fill_we_i,
  input logic                 inv_all_i,
  input logic                 fill_err_i,
  input icache_pkg::mem_req_t mem_req_i,
  input icache_pkg::mem_rsp_t mem_rsp_i
);

  int unsigned fail_cnt = 0;
  logic        inv_all_q;
  logic        fill_err_q;
  logic        recover;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      inv_all_q  <= 1'b0;
      fill_err_q <= 1'b0;
    end
    else
    begin
      inv_all_q  <= inv_all_i;
      fill_err_q <= fill_err_i;
    end
  end

  // first recovery cycle
  assign recover = fill_we_i | (inv_all_q & ~inv_all_i) | fill_err_q;

  ////////////////////////////////////////
  // properties

  fill_inv_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fill_we_i && inv_all_i))
  else
  begin
    fail_cnt++;
    $error("fill write while invalidating");
  end

  valid_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> !stall_i)
  else
  begin
    fail_cnt++;
    $error("parcel valid while stalled");
  end

  // address held until the word is answered
  mem_adr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.req && !mem_rsp_i.ack && !mem_rsp_i.err
    |=> mem_req_i.req && $stable(mem_req_i.adr))
  else
  begin
    fail_cnt++;
    $error("memory request dropped or moved before its ack");
  end

  // long enough for one refill after recovery
  stall_end_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    recover |-> ##[1:64] !stall_i)
  else
  begin
    fail_cnt++;
    $error("stall held too long after recovery");
  end

endmodule

bind icache_top icache_sva i_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .stall_i    (stall_o),
  .valid_i    (parcel_o.valid),
  .fill_we_i  (fill_we),
  .inv_all_i  (invalidate_all),
  .fill_err_i (fill_err),
  .mem_req_i  (mem_req_o),
  .mem_rsp_i  (mem_rsp_i)
);

//--- sim/icache_tb.sv
// testbench for the instruction cache top level, one fetch in flight at a time
// memory words are a fixed pattern of their address, acks after 0 to 3 wait cycles
// one read error can be armed at a chosen word address

`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_tb;

  localparam int          TIMEOUT   = 200;
  localparam int          SET_SHIFT = `ICACHE_OFFS_BITS + `ICACHE_IDX_BITS;
  localparam logic [31:0] SEED      = 32'h50c1_a2d9;

  typedef struct {
    string               name;
    icache_pkg::parcel_t par;
    bit                  use_data;
  } expect_t;

  logic                   clk_i;
  logic                   rst_ni;
  icache_pkg::fetch_req_t fetch_req;
  logic                   flush;
  logic                   invalidate;
  logic                   clean_rdy;
  logic                   stall;
  icache_pkg::parcel_t    parcel;
  icache_pkg::mem_req_t   mem_req;
  icache_pkg::mem_rsp_t   mem_rsp;

  logic [31:0] adr_lfsr;
  logic [31:0] dly_lfsr;
  logic [31:0] err_adr;
  logic        err_armed;
  logic        rsp_done;
  int          wait_left;
  int          req_count;
  int          errors;
  int          checks;
  int          tests;
  expect_t     exp_q[$];

  icache_top i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_req_i  (fetch_req),
    .flush_i      (flush),
    .invalidate_i (invalidate),
    .clean_rdy_i  (clean_rdy),
    .stall_o      (stall),
    .parcel_o     (parcel),
    .mem_req_o    (mem_req),
    .mem_rsp_i    (mem_rsp)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
      #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // reference model

  // fibonacci lfsr, taps 32 22 2 1, new bits enter at the bottom
  function automatic logic [31:0] lfsr_adv(logic [31:0] s, int n);
    logic fb;
    for (int i = 0; i < n; i++)
    begin
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      s  = {s[30:0], fb};
    end
    return s;
  endfunction

  // memory contents, address rotated left by 7
  function automatic logic [31:0] mem_word(logic [31:0] adr);
    return {adr[24:0], adr[31:25]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic icache_pkg::parcel_t expected_parcel(icache_pkg::fetch_req_t rq,
                                                           bit fill_err);
    icache_pkg::parcel_t p;
    p            = '0;
    p.valid      = 1'b1;
    p.misaligned = rq.misaligned;
    p.pagefault  = rq.pagefault;
    // access fault and bus error share the error flag
    p.error      = rq.accfault | fill_err;
    if (!(rq.misaligned | rq.pagefault | rq.accfault | fill_err))
      p.data = mem_word({rq.adr.raw[31:2], 2'b00});
    return p;
  endfunction

  function automatic icache_pkg::fetch_req_t make_req(logic [31:0] adr, logic cacheable,
                                                      logic [2:0] faults);
    icache_pkg::fetch_req_t r;
    r.req        = 1'b1;
    r.adr.raw    = adr;
    r.cacheable  = cacheable;
    r.misaligned = faults[2];
    r.pagefault  = faults[1];
    r.accfault   = faults[0];
    return r;
  endfunction

  ////////////////////////////////////////
  // memory model

  // one word per request, answer after a random wait
  always @(negedge clk_i)
  begin
    mem_rsp = '0;
    if (mem_req.req !== 1'b1)
    begin
      rsp_done  = 1'b0;
      dly_lfsr  = lfsr_adv(dly_lfsr, 2);
      wait_left = dly_lfsr[1:0];
    end
    else if (!rsp_done)
    begin
      if (wait_left > 0)
        wait_left--;
      else
      begin
        rsp_done = 1'b1;
        req_count++;
        if (err_armed && mem_req.adr == err_adr)
        begin
          err_armed   = 1'b0;
          mem_rsp.err = 1'b1;
        end
        else
        begin
          mem_rsp.ack = 1'b1;
          mem_rsp.q   = mem_word(mem_req.adr);
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks

  task automatic check_parcel(input string name, input icache_pkg::parcel_t exp,
                              input icache_pkg::parcel_t act, input bit use_data);
    icache_pkg::parcel_t a;
    a = act;
    // faulted parcels carry no meaningful data
    if (!use_data)
      a.data = exp.data;
    checks++;
    if (a !== exp)
    begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act)
    begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // parcels compared mid low phase, inputs settled
  always @(negedge clk_i)
  begin
    expect_t e;
    #25;
    if (rst_ni === 1'b1 && parcel.valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("a parcel was delivered with no fetch pending at %0t", $time);
      end
      else
      begin
        e = exp_q.pop_front();
        check_parcel(e.name, e.par, parcel, e.use_data);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic pick_line(output logic [31:0] base);
    adr_lfsr = lfsr_adv(adr_lfsr, 28);
    base     = {adr_lfsr[27:0], 4'b0000};
  endtask

  // hold the request until stall drops, cycles counts the stalled ones
  task automatic run_fetch(input string name, input icache_pkg::fetch_req_t rq,
                           input bit fill_err, output int cycles);
    expect_t e;
    e.name     = name;
    e.par      = expected_parcel(rq, fill_err);
    e.use_data = !(rq.misaligned | rq.pagefault | rq.accfault | fill_err);
    @(negedge clk_i);
    exp_q.push_back(e);
    fetch_req = rq;
    cycles    = 0;
    #25;
    while (stall !== 1'b0 && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      #25;
      cycles++;
    end
    if (cycles >= TIMEOUT)
      abort_run({"fetch ", name, " still stalled after the timeout"});
    @(negedge clk_i);
    fetch_req = '0;
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("fetch %s ended without a parcel", name);
      exp_q.delete();
    end
  endtask

  task automatic fetch_checked(input string name, input icache_pkg::fetch_req_t rq,
                               input bit fill_err, input int exp_reads);
    int c0;
    int cycles;
    c0 = req_count;
    run_fetch(name, rq, fill_err, cycles);
    check_count({name, " reads"}, exp_reads, req_count - c0);
    // no memory traffic means an answer in the request cycle
    if (exp_reads == 0)
      check_count({name, " stall cycles"}, 0, cycles);
  endtask

  task automatic run_invalidate();
    int d;
    int n;
    @(negedge clk_i);
    invalidate = 1'b1;
    @(negedge clk_i);
    invalidate = 1'b0;
    adr_lfsr = lfsr_adv(adr_lfsr, 2);
    d        = adr_lfsr[1:0];
    repeat (d) @(negedge clk_i);
    clean_rdy = 1'b1;
    n = 0;
    #25;
    while (stall !== 1'b0 && n < TIMEOUT)
    begin
      @(negedge clk_i);
      #25;
      n++;
    end
    if (n >= TIMEOUT)
      abort_run("invalidate never released the stall");
    @(negedge clk_i);
    clean_rdy = 1'b0;
  endtask

  task automatic end_test(input string name, input int errors_at_start);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errors_at_start);
  endtask

  initial
  begin
    int          e0;
    int          w;
    int          k;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    rst_ni     = 1'b0;
    fetch_req  = '0;
    flush      = 1'b0;
    invalidate = 1'b0;
    clean_rdy  = 1'b0;
    mem_rsp    = '0;
    adr_lfsr   = SEED;
    dly_lfsr   = SEED;
    err_adr    = '0;
    err_armed  = 1'b0;
    rsp_done   = 1'b0;
    wait_left  = 0;
    req_count  = 0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // cold miss fills the line, the rest of it hits
    e0 = errors;
    pick_line(a);
    adr_lfsr = lfsr_adv(adr_lfsr, 2);
    w        = adr_lfsr[1:0];
    fetch_checked("cold_miss", make_req(a + 4 * w, 1'b1, 3'b000), 1'b0, 4);
    for (int i = 0; i < `ICACHE_LINE_WORDS; i++)
    begin
      if (i != w)
        fetch_checked("line_hit", make_req(a + 4 * i, 1'b1, 3'b000), 1'b0, 0);
    end
    end_test("cold_miss_then_hit", e0);

    // uncached words always go to memory
    e0 = errors;
    pick_line(a);
    for (int i = 0; i < 2; i++)
      fetch_checked("uncached", make_req(a + 8, 1'b0, 3'b000), 1'b0, 1);
    end_test("noncacheable", e0);

    e0 = errors;
    pick_line(a);
    fetch_checked("misaligned", make_req(a + 2, 1'b1, 3'b100), 1'b0, 0);
    fetch_checked("pagefault", make_req(a, 1'b1, 3'b010), 1'b0, 0);
    fetch_checked("accfault", make_req(a, 1'b1, 3'b001), 1'b0, 0);
    end_test("faults", e0);

    e0 = errors;
    pick_line(a);
    fetch_checked("inv_fill", make_req(a + 4, 1'b1, 3'b000), 1'b0, 4);
    fetch_checked("inv_hit", make_req(a + 4, 1'b1, 3'b000), 1'b0, 0);
    run_invalidate();
    fetch_checked("inv_refill", make_req(a + 4, 1'b1, 3'b000), 1'b0, 4);
    end_test("invalidate", e0);

    // three tags in one set, ways alternate
    e0 = errors;
    run_invalidate();
    pick_line(a);
    b = a ^ (32'd1 << SET_SHIFT);
    c = a ^ (32'd2 << SET_SHIFT);
    fetch_checked("repl_a", make_req(a, 1'b1, 3'b000), 1'b0, 4);
    fetch_checked("repl_b", make_req(b, 1'b1, 3'b000), 1'b0, 4);
    fetch_checked("repl_c", make_req(c, 1'b1, 3'b000), 1'b0, 4);
    fetch_checked("repl_b_hit", make_req(b, 1'b1, 3'b000), 1'b0, 0);
    fetch_checked("repl_a_miss", make_req(a, 1'b1, 3'b000), 1'b0, 4);
    end_test("replacement", e0);

    // burst stops at the failing word
    e0 = errors;
    pick_line(a);
    adr_lfsr = lfsr_adv(adr_lfsr, 4);
    k        = adr_lfsr[1:0];
    w        = adr_lfsr[3:2];
    @(negedge clk_i);
    err_adr   = a + 4 * k;
    err_armed = 1'b1;
    fetch_checked("fill_error", make_req(a + 4 * w, 1'b1, 3'b000), 1'b1, k + 1);
    fetch_checked("error_retry", make_req(a + 4 * w, 1'b1, 3'b000), 1'b0, 4);
    end_test("fill_error", e0);

    repeat (4) @(negedge clk_i);
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, i_dut.i_sva.fail_cnt);
    if (errors == 0 && i_dut.i_sva.fail_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- source/icache_fill.sv
// memory-side engine of the instruction cache
// one transfer at a time, a command arriving while busy waits its turn
// and makes the running transfer stop after its current word, unreported
// the memory port takes one word per request with a gap between requests

`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_fill
(
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  icache_pkg::fillcmd_e    cmd_i,
  input  icache_pkg::icache_adr_u adr_i,

  output icache_pkg::mem_req_t    mem_req_o,
  input  icache_pkg::mem_rsp_t    mem_rsp_i,

  output logic                    single_ack_o,
  output logic [`ICACHE_XLEN-1:0] single_q_o,
  output icache_pkg::line_t       line_o,
  output logic                    done_o,
  output logic                    err_o
);

  icache_pkg::fillcmd_e          pend_q;
  icache_pkg::icache_adr_u       pend_adr_q;
  icache_pkg::icache_adr_u       adr_q;
  icache_pkg::icache_adr_u       word_adr;
  icache_pkg::line_t             line_q;
  logic                          busy_q;
  logic                          req_q;
  logic                          line_mode_q;
  logic                          discard_q;
  logic [`ICACHE_WSEL_BITS-1:0]  cnt_q;
  logic                          active;
  logic                          last_word;
  logic                          drop;

  assign active    = busy_q & req_q;
  assign last_word = (cnt_q == `ICACHE_WSEL_BITS'(`ICACHE_LINE_WORDS - 1));

  // superseded transfers report nothing
  assign drop = discard_q | (cmd_i != icache_pkg::NOP);

  ////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pend_q      <= icache_pkg::NOP;
      busy_q      <= 1'b0;
      req_q       <= 1'b0;
      line_mode_q <= 1'b0;
      discard_q   <= 1'b0;
      cnt_q       <= '0;
    end
    else
    begin
      if (!busy_q)
      begin
        // start the queued command at word 0
        if (pend_q != icache_pkg::NOP)
        begin
          pend_q      <= icache_pkg::NOP;
          busy_q      <= 1'b1;
          req_q       <= 1'b1;
          line_mode_q <= (pend_q == icache_pkg::READ_LINE);
          discard_q   <= 1'b0;
          cnt_q       <= '0;
        end
      end
      else if (req_q)
      begin
        if (mem_rsp_i.ack || mem_rsp_i.err)
        begin
          req_q <= 1'b0;
          if (mem_rsp_i.err || !line_mode_q || last_word || drop)
            busy_q <= 1'b0;
          else
            cnt_q <= cnt_q + 1'b1;
        end
      end
      // gap cycle over
      else if (discard_q)
        busy_q <= 1'b0;
      else
        req_q <= 1'b1;

      // queue new command
      if (cmd_i != icache_pkg::NOP)
      begin
        pend_q <= cmd_i;
        if (busy_q)
          discard_q <= 1'b1;
      end
    end
  end

  // addresses and line data
  always_ff @(posedge clk_i)
  begin
    if (cmd_i != icache_pkg::NOP)
      pend_adr_q <= adr_i;
    if (!busy_q && pend_q != icache_pkg::NOP)
      adr_q <= pend_adr_q;
    if (active && mem_rsp_i.ack && line_mode_q)
      line_q[cnt_q] <= mem_rsp_i.q;
  end

  ////////////////////////////////////////
  // memory port

  // bursts walk the line from its base
  always_comb
  begin
    word_adr = adr_q;
    if (line_mode_q)
      word_adr.f.wsel = cnt_q;
  end

  assign mem_req_o.req = req_q;
  assign mem_req_o.adr = word_adr.raw;

  ////////////////////////////////////////
  // results

  assign single_ack_o = active & (mem_rsp_i.ack | mem_rsp_i.err) & ~line_mode_q & ~drop;
  assign single_q_o   = mem_rsp_i.q;
  assign done_o       = active & mem_rsp_i.ack & line_mode_q & last_word & ~drop;
  assign err_o        = active & mem_rsp_i.err & ~drop;
  assign line_o       = line_q;

endmodule

//--- source/icache_hit.sv
// hit stage of the instruction cache with one fetch in flight at a time
// the core must hold req_i stable while stall_o is high
// hits and faulted fetches answer in the request cycle
// clean_rdy_i is a level from the data cache, sampled only while invalidating

`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_hit
(
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  icache_pkg::fetch_req_t      req_i,
  input  logic                        flush_i,
  input  logic                        invalidate_i,
  input  logic                        clean_rdy_i,
  output logic                        stall_o,
  output icache_pkg::parcel_t         parcel_o,

  output icache_pkg::icache_adr_u     lookup_adr_o,
  input  logic                        hit_i,
  input  icache_pkg::line_t           hit_line_i,
  input  logic [`ICACHE_WAY_BITS-1:0] victim_way_i,
  output logic                        invalidate_all_o,
  output logic                        fill_we_o,
  output logic [`ICACHE_WAY_BITS-1:0] fill_way_o,

  output icache_pkg::fillcmd_e        fill_cmd_o,
  output icache_pkg::icache_adr_u     fill_adr_o,
  input  logic                        single_ack_i,
  input  logic [`ICACHE_XLEN-1:0]     single_q_i,
  input  logic                        fill_done_i,
  input  logic                        fill_err_i
);

  typedef enum logic [2:0] {
    ARMED,
    INVALIDATE,
    NONCACHEABLE,
    READ,
    RECOVER0,
    RECOVER1
  } state_e;

  state_e                  state_q;
  logic                    inv_hold_q;
  logic                    inv_pend;
  logic                    fault;
  logic                    valid_req;
  logic                    cache_ack;
  logic                    fault_ack;
  logic [`ICACHE_XLEN-1:0] cache_q;

  ////////////////////////////////////////
  // request qualification

  assign fault     = req_i.misaligned | req_i.pagefault | req_i.accfault;
  assign valid_req = req_i.req & ~fault & ~flush_i;

  // invalidate pulse kept until the FSM takes it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inv_hold_q <= 1'b0;
    else
      inv_hold_q <= invalidate_i | (inv_hold_q & ~invalidate_all_o);
  end

  assign inv_pend = invalidate_i | inv_hold_q;

  // answered without leaving ARMED
  assign cache_ack = valid_req & req_i.cacheable & hit_i & ~inv_pend;
  assign fault_ack = req_i.req & fault & ~flush_i & ~inv_pend;

  ////////////////////////////////////////
  // state machine

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q          <= ARMED;
      invalidate_all_o <= 1'b0;
      fill_we_o        <= 1'b0;
      fill_way_o       <= '0;
      fill_cmd_o       <= icache_pkg::NOP;
    end
    else
    begin
      // command and write strobe are single-cycle
      fill_cmd_o <= icache_pkg::NOP;
      fill_we_o  <= 1'b0;

      unique case (state_q)
        ARMED:
        begin
          if (inv_pend)
          begin
            state_q          <= INVALIDATE;
            invalidate_all_o <= 1'b1;
          end
          else if (valid_req && !req_i.cacheable)
          begin
            state_q    <= NONCACHEABLE;
            fill_cmd_o <= icache_pkg::READ_SINGLE;
          end
          else if (valid_req && !hit_i)
          begin
            // way picked now, written when the line is in
            state_q    <= READ;
            fill_cmd_o <= icache_pkg::READ_LINE;
            fill_way_o <= victim_way_i;
          end
        end

        // wait for the data cache to finish cleaning
        INVALIDATE:
        begin
          if (clean_rdy_i)
          begin
            state_q          <= RECOVER0;
            invalidate_all_o <= 1'b0;
          end
        end

        // flush leaves the word to the filler
        NONCACHEABLE:
        begin
          if (flush_i || single_ack_i)
            state_q <= ARMED;
        end

        READ:
        begin
          if (fill_done_i)
          begin
            state_q   <= RECOVER0;
            fill_we_o <= 1'b1;
          end
          else if (fill_err_i)
            state_q <= RECOVER0;
        end

        // line written here
        RECOVER0:
          state_q <= RECOVER1;

        // arrays read back with the held request
        RECOVER1:
          state_q <= ARMED;

        default:
          state_q <= ARMED;
      endcase
    end
  end

  // word-aligned fetch address for the filler
  always_ff @(posedge clk_i)
  begin
    if (state_q == ARMED && valid_req)
      fill_adr_o.raw <= {req_i.adr.raw[`ICACHE_PLEN-1:`ICACHE_BSEL_BITS],
                         {`ICACHE_BSEL_BITS{1'b0}}};
  end

  // held request also selects the set of the fill write
  assign lookup_adr_o = req_i.adr;

  ////////////////////////////////////////
  // stall

  always_comb
  begin
    unique case (state_q)
      ARMED:
        stall_o = inv_pend | (valid_req & ~(req_i.cacheable & hit_i));
      NONCACHEABLE:
        stall_o = ~flush_i & ~single_ack_i;
      // released only by an error
      READ:
        stall_o = ~fill_err_i;
      default:
        stall_o = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // parcel

  // word select from the hit line
  assign cache_q = hit_line_i[req_i.adr.f.wsel];

  always_comb
  begin
    parcel_o.valid      = 1'b0;
    parcel_o.data       = cache_q;
    parcel_o.error      = 1'b0;
    parcel_o.misaligned = 1'b0;
    parcel_o.pagefault  = 1'b0;

    unique case (state_q)
      ARMED:
      begin
        parcel_o.valid      = cache_ack | fault_ack;
        parcel_o.error      = fault_ack & req_i.accfault;
        parcel_o.misaligned = fault_ack & req_i.misaligned;
        parcel_o.pagefault  = fault_ack & req_i.pagefault;
      end
      NONCACHEABLE:
      begin
        parcel_o.valid = single_ack_i & ~flush_i;
        parcel_o.data  = single_q_i;
        parcel_o.error = single_ack_i & ~flush_i & fill_err_i;
      end
      // failed fill reported at once
      READ:
      begin
        parcel_o.valid = fill_err_i;
        parcel_o.error = fill_err_i;
      end
      default:
        parcel_o.valid = 1'b0;
    endcase
  end

endmodule

//--- source/icache_mem.sv
// tag, valid and data arrays of the instruction cache
// lookup is combinational, writes land on the clock edge
// the replacement pointer per set steps on every fill of that set

`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_mem
(
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  icache_pkg::icache_adr_u     lookup_adr_i,
  output logic                        hit_o,
  output icache_pkg::line_t           hit_line_o,
  output logic [`ICACHE_WAY_BITS-1:0] victim_way_o,

  input  logic                        invalidate_all_i,
  input  logic                        fill_we_i,
  input  logic [`ICACHE_WAY_BITS-1:0] fill_way_i,
  input  icache_pkg::line_t           fill_line_i
);

  logic [`ICACHE_TAG_BITS-1:0]                   tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::line_t                             data_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0]     valid_q;
  logic [`ICACHE_SETS-1:0][`ICACHE_WAY_BITS-1:0] victim_q;

  logic [`ICACHE_IDX_BITS-1:0] idx;
  logic [`ICACHE_TAG_BITS-1:0] core_tag;
  logic [`ICACHE_WAYS-1:0]     way_hit;

  ////////////////////////////////////////
  // lookup

  assign idx      = lookup_adr_i.f.idx;
  // tag is the top of the address
  assign core_tag = lookup_adr_i.raw[`ICACHE_PLEN-1 -: `ICACHE_TAG_BITS];

  // ways never hold the same tag, so an OR mux is enough
  always_comb
  begin
    hit_line_o = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      way_hit[w] = valid_q[w][idx] & (tag_mem[w][idx] == core_tag);
      if (way_hit[w])
        hit_line_o |= data_mem[w][idx];
    end
  end

  assign hit_o        = |way_hit;
  assign victim_way_o = victim_q[idx];

  ////////////////////////////////////////
  // arrays

  always_ff @(posedge clk_i)
  begin
    if (fill_we_i)
    begin
      tag_mem[fill_way_i][idx]  <= core_tag;
      data_mem[fill_way_i][idx] <= fill_line_i;
    end
  end

  // valid bits and replacement pointers
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q  <= '0;
      victim_q <= '0;
    end
    else if (invalidate_all_i)
      valid_q <= '0;
    else if (fill_we_i)
    begin
      valid_q[fill_way_i][idx] <= 1'b1;
      // two ways alternate
      victim_q[idx] <= victim_q[idx] + 1'b1;
    end
  end

endmodule

//--- source/icache_pkg.sv
// types shared by the instruction cache blocks
// all widths come from the cache constants header

`include "icache_consts.svh"

package icache_pkg;

  ////////////////////////////////////////
  // address

  // one address word, used raw or split into its cache fields
  typedef union packed {
    logic [`ICACHE_PLEN-1:0] raw;
    struct packed {
      logic [`ICACHE_TAG_BITS-1:0]  tag;
      logic [`ICACHE_IDX_BITS-1:0]  idx;
      logic [`ICACHE_WSEL_BITS-1:0] wsel;
      logic [`ICACHE_BSEL_BITS-1:0] bsel;
    } f;
  } icache_adr_u;

  ////////////////////////////////////////
  // core side

  typedef struct packed {
    logic        req;
    icache_adr_u adr;
    logic        cacheable;
    logic        misaligned;
    logic        pagefault;
    logic        accfault;
  } fetch_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`ICACHE_XLEN-1:0] data;
    logic                    error;
    logic                    misaligned;
    logic                    pagefault;
  } parcel_t;

  ////////////////////////////////////////
  // memory side

  typedef struct packed {
    logic                    req;
    logic [`ICACHE_PLEN-1:0] adr;
  } mem_req_t;

  typedef struct packed {
    logic                    ack;
    logic                    err;
    logic [`ICACHE_XLEN-1:0] q;
  } mem_rsp_t;

  // controller to filler, valid for one cycle
  typedef enum logic [1:0] {NOP, READ_LINE, READ_SINGLE} fillcmd_e;

  // word 0 sits in the low bits
  typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_XLEN-1:0] line_t;

endpackage

//--- source/icache_top.sv
// instruction cache top level with core port and a single memory port
// one memory transfer at a time, word reads only

`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_top
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  icache_pkg::fetch_req_t fetch_req_i,
  input  logic                   flush_i,
  input  logic                   invalidate_i,
  input  logic                   clean_rdy_i,
  output logic                   stall_o,
  output icache_pkg::parcel_t    parcel_o,

  output icache_pkg::mem_req_t   mem_req_o,
  input  icache_pkg::mem_rsp_t   mem_rsp_i
);

  ////////////////////////////////////////
  // internal wiring

  // controller to arrays
  icache_pkg::icache_adr_u     lookup_adr;
  logic                        hit;
  icache_pkg::line_t           hit_line;
  logic [`ICACHE_WAY_BITS-1:0] victim_way;
  logic                        invalidate_all;
  logic                        fill_we;
  logic [`ICACHE_WAY_BITS-1:0] fill_way;

  // controller to filler
  icache_pkg::fillcmd_e        fill_cmd;
  icache_pkg::icache_adr_u     fill_adr;
  logic                        single_ack;
  logic [`ICACHE_XLEN-1:0]     single_q;
  logic                        fill_done;
  logic                        fill_err;
  icache_pkg::line_t           fill_line;

  icache_hit i_hit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (fetch_req_i),
    .flush_i          (flush_i),
    .invalidate_i     (invalidate_i),
    .clean_rdy_i      (clean_rdy_i),
    .stall_o          (stall_o),
    .parcel_o         (parcel_o),
    .lookup_adr_o     (lookup_adr),
    .hit_i            (hit),
    .hit_line_i       (hit_line),
    .victim_way_i     (victim_way),
    .invalidate_all_o (invalidate_all),
    .fill_we_o        (fill_we),
    .fill_way_o       (fill_way),
    .fill_cmd_o       (fill_cmd),
    .fill_adr_o       (fill_adr),
    .single_ack_i     (single_ack),
    .single_q_i       (single_q),
    .fill_done_i      (fill_done),
    .fill_err_i       (fill_err)
  );

  icache_mem i_mem (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lookup_adr_i     (lookup_adr),
    .hit_o            (hit),
    .hit_line_o       (hit_line),
    .victim_way_o     (victim_way),
    .invalidate_all_i (invalidate_all),
    .fill_we_i        (fill_we),
    .fill_way_i       (fill_way),
    .fill_line_i      (fill_line)
  );

  icache_fill i_fill (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (fill_cmd),
    .adr_i        (fill_adr),
    .mem_req_o    (mem_req_o),
    .mem_rsp_i    (mem_rsp_i),
    .single_ack_o (single_ack),
    .single_q_o   (single_q),
    .line_o       (fill_line),
    .done_o       (fill_done),
    .err_o        (fill_err)
  );

endmodule
